/* verilog/dp_lane_map_config.svh */
// DP lane mapper configuration
// Lane counts, symbol and channel word layout, lane swaps and timing constants

`ifndef DP_LANE_MAP_CONFIG_SVH
`define DP_LANE_MAP_CONFIG_SVH

`define DP_LANES            4           // DP lanes and SERDES channels
`define DP_SPL              4           // Symbols per lane per clock
`define DP_TX_SYM_W         11          // Data, control, disparity value, disparity force
`define DP_RX_SYM_W         9           // Data and control
`define DP_TX_DVAL_BIT      9           // Disparity value (0-negative / 1-positive)
`define DP_TX_DFORCE_BIT    10          // Disparity force (0-automatic / 1-force)
`define DP_PHY_W            80          // SERDES channel word
`define DP_PHY_SLOT_W       10          // Symbol slot spacing
`define DP_PHY_DFORCE_LSB   40
`define DP_PHY_DVAL_LSB     44

// Channel maps, one 2-bit channel number per lane, lane 0 in the low bits
`define DP_CH_SEL_W         2
`define DP_TX_CH_MAP        8'hE1       // Lanes 0..3 -> channels 1, 0, 2, 3
`define DP_RX_CH_MAP        8'h4B       // Lanes 0..3 <- channels 3, 2, 0, 1

`define DP_RST_CNT_W        10
`define DP_HB_BEAT          25_000_000  // Heartbeat half-period in system cycles
`define DP_LED_W            8

`endif

/* verilog/dp_lane_map_pkg.sv */
// DP lane mapper types
// Symbols, symbol buses and SERDES channel words shared by the mapper blocks

`include "dp_lane_map_config.svh"

package dp_lane_map_pkg;

    // Link symbols
    typedef logic [`DP_TX_SYM_W-1:0] tx_sym_t;
    typedef logic [`DP_RX_SYM_W-1:0] rx_sym_t;

    // Lane-major buses, symbol s of lane l at index l*SPL+s
    typedef tx_sym_t [`DP_LANES*`DP_SPL-1:0] tx_sym_bus_t;
    typedef rx_sym_t [`DP_LANES*`DP_SPL-1:0] rx_sym_bus_t;

    // SERDES side
    typedef logic [`DP_PHY_W-1:0] phy_word_t;
    typedef phy_word_t [`DP_LANES-1:0] phy_bus_t;     // Indexed by channel

    // Board LEDs
    typedef logic [`DP_LED_W-1:0] led_t;

endpackage

/* verilog/dp_reset_gen.sv */
// Link reset generator
// Holds the link reset after PLL lock until a saturating counter runs out.
// Losing lock restarts the count.

`timescale 1ns/1ns
`default_nettype none

`include "dp_lane_map_config.svh"

module dp_reset_gen
(
    input  wire logic   sys_clk_i,
    input  wire logic   rst_n_i,
    input  wire logic   pll_lock_i,
    output logic        link_rst_o
);

    logic [`DP_RST_CNT_W-1:0] rst_cnt;

    always_ff @(posedge sys_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rst_cnt    <= '0;
            link_rst_o <= 1'b1;
        end
        else if (!pll_lock_i)
        begin
            // Lock lost, start over
            rst_cnt    <= '0;
            link_rst_o <= 1'b1;
        end
        else
        begin
            if (!(&rst_cnt))
                rst_cnt <= rst_cnt + 1'b1;  // Count while locked
            else
                link_rst_o <= 1'b0;         // Counter saturated
        end
    end

endmodule

`default_nettype wire

/* verilog/dp_tx_lane_map.sv */
// Transmit lane mapper
// Packs the sixteen link symbols into four SERDES channel words, following
// the board lane swap. Data and control go into 10-bit slots, the disparity
// fields are gathered above them. Output is registered and held at zero
// during link reset.

`timescale 1ns/1ns
`default_nettype none

`include "dp_lane_map_config.svh"

module dp_tx_lane_map
(
    input  wire logic                           sys_clk_i,
    input  wire logic                           rst_n_i,
    input  wire logic                           link_rst_i,
    input  wire dp_lane_map_pkg::tx_sym_bus_t   tx_sym_i,
    output dp_lane_map_pkg::phy_bus_t           phy_tx_o
);

    localparam logic [`DP_LANES*`DP_CH_SEL_W-1:0] TX_CH_MAP = `DP_TX_CH_MAP;

    dp_lane_map_pkg::phy_bus_t tx_map;

    always_comb
    begin
        logic [`DP_CH_SEL_W-1:0]    ch;
        dp_lane_map_pkg::tx_sym_t   sym;

        tx_map = '0;    // Unused slot bits and 48-79 stay low
        for (int l = 0; l < `DP_LANES; l++)
        begin
            ch = TX_CH_MAP[l*`DP_CH_SEL_W +: `DP_CH_SEL_W];   // Target channel
            for (int s = 0; s < `DP_SPL; s++)
            begin
                sym = tx_sym_i[l*`DP_SPL + s];

                // Data and control flag
                tx_map[ch][s*`DP_PHY_SLOT_W +: `DP_RX_SYM_W] = sym[`DP_RX_SYM_W-1:0];

                // Disparity bits in symbol order
                tx_map[ch][`DP_PHY_DFORCE_LSB + s] = sym[`DP_TX_DFORCE_BIT];
                tx_map[ch][`DP_PHY_DVAL_LSB + s]   = sym[`DP_TX_DVAL_BIT];
            end
        end
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            phy_tx_o <= '0;
        else if (link_rst_i)
            phy_tx_o <= '0;     // Quiet link while in reset
        else
            phy_tx_o <= tx_map;
    end

endmodule

`default_nettype wire

/* verilog/dp_rx_lane_map.sv */
// Receive lane mapper
// Unpacks four SERDES channel words into sixteen receive symbols using the
// board receive lane swap. Slot bit 9 is dropped. Output is registered.

`timescale 1ns/1ns
`default_nettype none

`include "dp_lane_map_config.svh"

module dp_rx_lane_map
(
    input  wire logic                       sys_clk_i,
    input  wire logic                       rst_n_i,
    input  wire dp_lane_map_pkg::phy_bus_t  phy_rx_i,
    output dp_lane_map_pkg::rx_sym_bus_t    rx_sym_o
);

    localparam logic [`DP_LANES*`DP_CH_SEL_W-1:0] RX_CH_MAP = `DP_RX_CH_MAP;

    dp_lane_map_pkg::rx_sym_bus_t rx_map;

    always_comb
    begin
        logic [`DP_CH_SEL_W-1:0] ch;

        for (int l = 0; l < `DP_LANES; l++)
        begin
            // Source channel for this lane
            ch = RX_CH_MAP[l*`DP_CH_SEL_W +: `DP_CH_SEL_W];
            for (int s = 0; s < `DP_SPL; s++)
                rx_map[l*`DP_SPL + s] = phy_rx_i[ch][s*`DP_PHY_SLOT_W +: `DP_RX_SYM_W];
        end
    end

    // Not gated by link reset
    always_ff @(posedge sys_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
            rx_sym_o <= '0;
        else
            rx_sym_o <= rx_map;
    end

endmodule

`default_nettype wire

/* verilog/dp_status_led.sv */
// Status LEDs
// Bit 0 is the system heartbeat, running once the link reset is released.
// Bit 1 shows all SERDES channels ready, bit 2 the hot-plug level.

`timescale 1ns/1ns
`default_nettype none

`include "dp_lane_map_config.svh"

module dp_status_led
#(
    parameter int HB_BEAT = `DP_HB_BEAT     // Half-period in system cycles
)
(
    input  wire logic                   sys_clk_i,
    input  wire logic                   rst_n_i,
    input  wire logic                   link_rst_i,
    input  wire logic [`DP_LANES-1:0]   phy_rdy_i,
    input  wire logic                   hpd_n_i,
    output dp_lane_map_pkg::led_t       led_o
);

    localparam int HB_CNT_W = (HB_BEAT > 1) ? $clog2(HB_BEAT) : 1;
    localparam logic [HB_CNT_W-1:0] HB_LAST = HB_CNT_W'(HB_BEAT - 1);

    logic [HB_CNT_W-1:0]    hb_cnt;
    logic                   hb;
    logic                   rdy_q;
    logic                   hpd_q;

    // Heartbeat
    always_ff @(posedge sys_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            hb_cnt <= '0;
            hb     <= 1'b0;
        end
        else if (link_rst_i)
        begin
            hb_cnt <= '0;
            hb     <= 1'b0;
        end
        else if (hb_cnt == HB_LAST)
        begin
            hb_cnt <= '0;
            hb     <= ~hb;      // Toggle every HB_BEAT cycles
        end
        else
            hb_cnt <= hb_cnt + 1'b1;
    end

    always_ff @(posedge sys_clk_i or negedge rst_n_i)
    begin
        if (!rst_n_i)
        begin
            rdy_q <= 1'b0;
            hpd_q <= 1'b0;
        end
        else
        begin
            rdy_q <= &phy_rdy_i;    // All channels ready
            hpd_q <= ~hpd_n_i;      // Hot plug pin is inverted on the board
        end
    end

    always_comb
    begin
        led_o    = '0;  // Upper LEDs unused
        led_o[0] = hb;
        led_o[1] = rdy_q;
        led_o[2] = hpd_q;
    end

endmodule

`default_nettype wire

/* verilog/dp_lane_map_top.sv */
// DP lane mapper top level
// Link reset generation, transmit and receive lane mapping between the DP
// link layers and a quad SERDES, and the board status LEDs.

`timescale 1ns/1ns
`default_nettype none

`include "dp_lane_map_config.svh"

module dp_lane_map_top
#(
    parameter int HB_BEAT = `DP_HB_BEAT
)
(
    // Clock and reset
    input  wire logic                           sys_clk_i,
    input  wire logic                           rst_n_i,
    input  wire logic                           pll_lock_i,     // System PLL lock

    // Transmit link
    input  wire dp_lane_map_pkg::tx_sym_bus_t   tx_sym_i,
    output dp_lane_map_pkg::phy_bus_t           phy_tx_o,

    // Receive link
    input  wire dp_lane_map_pkg::phy_bus_t      phy_rx_i,
    output dp_lane_map_pkg::rx_sym_bus_t        rx_sym_o,

    // Status
    input  wire logic [`DP_LANES-1:0]           phy_rdy_i,      // SERDES channel ready
    input  wire logic                           hpd_n_i,        // Hot plug, active low
    output dp_lane_map_pkg::led_t               led_o,
    output logic                                link_rst_o
);

    logic link_rst;

    // Link reset
    dp_reset_gen
    i_dp_reset_gen
    (
        .sys_clk_i      (sys_clk_i),
        .rst_n_i        (rst_n_i),
        .pll_lock_i     (pll_lock_i),
        .link_rst_o     (link_rst)
    );

    // Transmit mapping
    dp_tx_lane_map
    i_dp_tx_lane_map
    (
        .sys_clk_i      (sys_clk_i),
        .rst_n_i        (rst_n_i),
        .link_rst_i     (link_rst),
        .tx_sym_i       (tx_sym_i),
        .phy_tx_o       (phy_tx_o)
    );

    // Receive mapping
    dp_rx_lane_map
    i_dp_rx_lane_map
    (
        .sys_clk_i      (sys_clk_i),
        .rst_n_i        (rst_n_i),
        .phy_rx_i       (phy_rx_i),
        .rx_sym_o       (rx_sym_o)
    );

    // LEDs
    dp_status_led
    #(
        .HB_BEAT        (HB_BEAT)
    )
    i_dp_status_led
    (
        .sys_clk_i      (sys_clk_i),
        .rst_n_i        (rst_n_i),
        .link_rst_i     (link_rst),
        .phy_rdy_i      (phy_rdy_i),
        .hpd_n_i        (hpd_n_i),
        .led_o          (led_o)
    );

    assign link_rst_o = link_rst;

endmodule

`default_nettype wire

/* testbench/tb_dp_lane_map_top.sv */
// Testbench for the DP lane mapper top level
// Checks link reset timing, transmit gating and packing, receive unpacking
// and the status LEDs. Vectors come from a file and from an LFSR.

`timescale 1ns/1ns

`include "dp_lane_map_config.svh"

module tb_dp_lane_map_top;

    localparam int TX_W    = `DP_LANES * `DP_SPL * `DP_TX_SYM_W;
    localparam int RX_W    = `DP_LANES * `DP_SPL * `DP_RX_SYM_W;
    localparam int BUS_W   = `DP_LANES * `DP_PHY_W;
    localparam int TIMEOUT = 2000;      // Cycles allowed for any wait

    logic               sys_clk;
    logic               rst_n;
    logic               pll_lock;
    logic [TX_W-1:0]    tx_sym;
    logic [BUS_W-1:0]   phy_tx;
    logic [BUS_W-1:0]   phy_rx;
    logic [RX_W-1:0]    rx_sym;
    logic [3:0]         phy_rdy;
    logic               hpd_n;
    logic [7:0]         led;
    logic               link_rst;
    logic [15:0]        lfsr;
    int                 pass_cnt;
    int                 fail_cnt;

    dp_lane_map_top #(.HB_BEAT(8)) i_dp_lane_map_top
    (
        .sys_clk_i  (sys_clk),
        .rst_n_i    (rst_n),
        .pll_lock_i (pll_lock),
        .tx_sym_i   (tx_sym),
        .phy_tx_o   (phy_tx),
        .phy_rx_i   (phy_rx),
        .rx_sym_o   (rx_sym),
        .phy_rdy_i  (phy_rdy),
        .hpd_n_i    (hpd_n),
        .led_o      (led),
        .link_rst_o (link_rst)
    );

    always #20 sys_clk = ~sys_clk;

    task automatic check_value(input logic [255:0] name, input logic [BUS_W-1:0] exp,
                               input logic [BUS_W-1:0] act);
        if (act !== exp)
        begin
            $display("mismatch %0s expected %h actual %h", name, exp, act);
            fail_cnt++;
        end
        else
        begin
            $display("ok %0s", name);
            pass_cnt++;
        end
    endtask

    task automatic report(input logic [255:0] name, input bit ok, input logic [255:0] what);
        if (ok)
        begin
            $display("ok %0s", name);
            pass_cnt++;
        end
        else
        begin
            $display("error %0s: %0s", name, what);
            fail_cnt++;
        end
    endtask

    // Galois LFSR, x^16 + x^14 + x^13 + x^11 + 1
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Expected channel words built from the lane swap and slot layout
    function automatic logic [BUS_W-1:0] pack_tx(input logic [TX_W-1:0] syms);
        logic [BUS_W-1:0] w;
        int ch;
        int base;
        int sb;
        w = '0;
        for (int lane = 0; lane < 4; lane++)
        begin
            case (lane)
                0:       ch = 1;
                1:       ch = 0;
                default: ch = lane;
            endcase
            base = ch * 80;
            for (int s = 0; s < 4; s++)
            begin
                sb = (lane * 4 + s) * 11;
                for (int b = 0; b < 9; b++)
                    w[base + s*10 + b] = syms[sb + b];
                w[base + 40 + s] = syms[sb + 10];   // Force
                w[base + 44 + s] = syms[sb + 9];    // Value
            end
        end
        return w;
    endfunction

    task automatic run_tx(input logic [255:0] name, input logic [BUS_W-1:0] in_v,
                          input logic [BUS_W-1:0] exp_v);
        @(posedge sys_clk);
        tx_sym <= in_v[TX_W-1:0];
        @(posedge sys_clk);
        #1;
        check_value(name, exp_v, phy_tx);
    endtask

    task automatic run_rx(input logic [255:0] name, input logic [BUS_W-1:0] in_v,
                          input logic [BUS_W-1:0] exp_v);
        @(posedge sys_clk);
        phy_rx <= in_v;
        @(posedge sys_clk);
        #1;
        check_value(name, exp_v, BUS_W'(rx_sym));
    endtask

    // exp_led holds the expected LED bits 2 and 1
    task automatic run_leds(input logic [255:0] name, input logic [3:0] rdy, input logic hpd,
                            input logic [1:0] exp_led);
        @(posedge sys_clk);
        phy_rdy <= rdy;
        hpd_n   <= hpd;
        @(posedge sys_clk);
        #1;
        check_value(name, BUS_W'({5'b0, exp_led}), BUS_W'(led[7:1]));
    endtask

    // Counts edges until led bit 0 reaches the given level
    task automatic wait_hb(input logic level, output int cycles, output bit seen);
        cycles = 0;
        seen   = 0;
        while (!seen && cycles < TIMEOUT)
        begin
            @(posedge sys_clk);
            #1;
            cycles++;
            if (led[0] === level)
                seen = 1;
        end
    endtask

    initial
    begin
        int             cycles;
        int             fd;
        int             n;
        bit             done;
        bit             gate_ok;
        bit             hb_ok;
        string          line;
        logic [255:0]   kind;
        logic [255:0]   name;
        logic [BUS_W-1:0] in_v;
        logic [BUS_W-1:0] exp_v;
        logic [TX_W-1:0]  rnd;

        sys_clk  = 0;
        rst_n    = 0;
        pll_lock = 1;
        tx_sym   = '0;
        phy_rx   = '0;
        phy_rdy  = '0;
        hpd_n    = 1;
        lfsr     = 16'd1714;
        pass_cnt = 0;
        fail_cnt = 0;

        repeat (16) @(posedge sys_clk);
        rst_n  <= 1;
        tx_sym <= {16{11'h7FF}};    // Must not leak out during link reset

        cycles  = 0;
        done    = 0;
        gate_ok = 1;
        hb_ok   = 1;
        while (!done && cycles < TIMEOUT)
        begin
            @(posedge sys_clk);
            #1;
            cycles++;
            if (phy_tx !== '0)
                gate_ok = 0;
            if (led[0] !== 1'b0)
                hb_ok = 0;
            if (link_rst === 1'b0)
                done = 1;
        end
        if (!done)
            report("reset_release", 0, "link reset was never released");
        else
            check_value("reset_release", BUS_W'(1024), BUS_W'(cycles));
        report("tx_gating", gate_ok, "phy_tx_o was not zero during link reset");
        report("hb_in_reset", hb_ok, "heartbeat moved during link reset");

        // Heartbeat, first toggle 8 edges after release, then every 8
        wait_hb(1'b1, cycles, done);
        if (!done)
            report("hb_first", 0, "heartbeat never toggled");
        else
            check_value("hb_first", BUS_W'(8), BUS_W'(cycles));
        wait_hb(1'b0, cycles, done);
        if (!done)
            report("hb_period", 0, "heartbeat stopped toggling");
        else
            check_value("hb_period", BUS_W'(8), BUS_W'(cycles));

        run_leds("led_idle", 4'h0, 1'b1, 2'b00);
        run_leds("led_partial_rdy", 4'h7, 1'b1, 2'b00);
        run_leds("led_all_rdy", 4'hF, 1'b1, 2'b01);
        run_leds("led_hpd", 4'hF, 1'b0, 2'b11);
        run_leds("led_hpd_only", 4'hB, 1'b0, 2'b10);

        fd = $fopen("testbench/dp_lane_map_tests.txt", "r");
        if (fd == 0)
            report("tests_file", 0, "could not open the test vector file");
        else
        begin
            while (!$feof(fd))
            begin
                line = "";
                void'($fgets(line, fd));
                if (line.len() == 0 || line.getc(0) == "#" || line.getc(0) == 8'h0a)
                    continue;
                n = $sscanf(line, "%s %s %h %h", kind, name, in_v, exp_v);
                if (n != 4)
                    report("tests_file", 0, "malformed line in the test vector file");
                else if (kind == "tx")
                    run_tx(name, in_v, exp_v);
                else if (kind == "rx")
                    run_rx(name, in_v, exp_v);
                else
                    report(name, 0, "unknown test kind");
            end
            $fclose(fd);
        end

        for (int t = 0; t < 8; t++)
        begin
            for (int i = 0; i < TX_W; i++)
            begin
                rnd[i] = lfsr[0];
                lfsr   = lfsr_next(lfsr);
            end
            $sformat(name, "lfsr_tx_%0d", t);
            run_tx(name, BUS_W'(rnd), pack_tx(rnd));
        end

        // Losing lock raises the link reset on the next edge
        @(posedge sys_clk);
        pll_lock <= 0;
        @(posedge sys_clk);
        #1;
        report("lock_drop", link_rst === 1'b1, "link reset did not rise after lock loss");

        $display("tests passed %0d failed %0d", pass_cnt, fail_cnt);
        if (fail_cnt == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

/* dp_lane_map_top.f */
+incdir+verilog
verilog/dp_lane_map_pkg.sv
verilog/dp_reset_gen.sv
verilog/dp_tx_lane_map.sv
verilog/dp_rx_lane_map.sv
verilog/dp_status_led.sv
verilog/dp_lane_map_top.sv
testbench/tb_dp_lane_map_top.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the DP lane mapper testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing \
    -f dp_lane_map_top.f \
    --top-module tb_dp_lane_map_top \
    -o sim_dp_lane_map
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/sim_dp_lane_map)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if echo "$out" | grep -qF '*** PASSED ***'; then
    exit 0
else
    exit 1
fi

/* testbench/dp_lane_map_tests.txt */
# kind(tx|rx) test_name input_hex expected_hex
# tx: input is tx_sym_i, expected is phy_tx_o; rx: input is phy_rx_i, expected is rx_sym_o
tx tx_zero 0 0
tx tx_l0s0_data 0ff ff00000000000000000000
tx tx_l1s0_ctrl 10000000000000 100
tx tx_l2s0_data 1a50000000000000000000000 1a50000000000000000000000000000000000000000
tx tx_l2s3_dforce 800000000000000000000000000000000 800000000000000000000000000000000000000000000000000
tx tx_l3s1_dval 100000000000000000000000000000000000000 200000000000000000000000000000000000000000000000000000000000000000000000
tx tx_l0_ones fffffffffff ff7fdff7fdff00000000000000000000
rx rx_zero 0 0
rx rx_c0s0_data 1ff 1ff000000000000000000
rx rx_c0s0_bit9 200 0
rx rx_c0_ones ffffffffffffffffffff fffffffff000000000000000000
rx rx_c1s1_data 2ac0000000000000000000000 15600000000000000000000000000000
rx rx_c2s2_data ff000000000000000000000000000000000000000000000 3fc0000000000000
rx rx_c3s3_data 5540000000000000000000000000000000000000000000000000000000000000000000 aa8000000
